//--- design/ntm_buf_if.sv
// Single read-write port of the augmented matrix buffer
// Read data is valid one cycle after an enabled read

`timescale 1ns/10ps

interface ntm_buf_if;
  import ntm_inverse_pkg::*;

  // Port enable, write when we is also high
  logic  en;
  logic  we;
  addr_t addr;
  elem_t wdata;
  // Registered read data
  elem_t rdata;

  modport controller (
    output en, we, addr, wdata,
    input  rdata
  );

  modport memory (
    input  en, we, addr, wdata,
    output rdata
  );

endinterface

//--- design/ntm_inverse_pkg.sv
// Shared types and constants of the matrix inversion engine
// Fixed matrix order of 4 and signed Q16.16 elements
// Several address and index formats assume this order and do not scale

package ntm_inverse_pkg;

  //////////////////////////////
  // Matrix geometry
  //////////////////////////////

  // Order of the square input matrix
  localparam int N_DIM = 4;
  // Augmented buffer holds A on the left and the inverse on the right
  localparam int AUG_COLS = 2 * N_DIM;

  //////////////////////////////
  // Fixed-point format
  //////////////////////////////

  localparam int DATA_W = 32;
  localparam int FRAC_BITS = 16;

  // Signed Q16.16 element
  typedef logic signed [DATA_W-1:0] elem_t;

  // 1.0 in Q16.16, used for the identity
  localparam elem_t Q_ONE = elem_t'(1 << FRAC_BITS);

  //////////////////////////////
  // Buffer addressing
  //////////////////////////////

  // 32 entries, row * AUG_COLS + column
  localparam int ADDR_W = 5;
  typedef logic [ADDR_W-1:0] addr_t;

  // Row or column index, wide enough to count one past the last row
  typedef logic [2:0] idx_t;

endpackage

//--- design/ntm_inverse_top.sv
// Matrix inversion engine top level
// Streams 16 Q16.16 elements in row-major order, inverse comes back the same way
// out_singular holds for the whole result when a pivot was zero

`timescale 1ns/10ps

module ntm_inverse_top (
  input  logic                   CLK,
  input  logic                   RST,

  // Input stream
  input  logic                   in_valid,
  output logic                   in_ready,
  input  ntm_inverse_pkg::elem_t in_data,

  // Result stream
  output logic                   out_valid,
  input  logic                   out_ready,
  output ntm_inverse_pkg::elem_t out_data,
  output logic                   out_last,
  output logic                   out_singular
);

  // Controller to divider and controller to buffer
  ntm_recip_if recip_bus ();
  ntm_buf_if   buf_bus ();

  ntm_matrix_inverse i_ctrl (
    .CLK          (CLK),
    .RST          (RST),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_data      (in_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_last     (out_last),
    .out_singular (out_singular),
    .recip        (recip_bus.controller),
    .buf_port     (buf_bus.controller)
  );

  // Augmented matrix, no reset
  ntm_matrix_buffer i_buf (
    .CLK      (CLK),
    .buf_port (buf_bus.memory)
  );

  // Pivot reciprocal
  ntm_scalar_reciprocal i_recip (
    .CLK   (CLK),
    .RST   (RST),
    .recip (recip_bus.divider)
  );

endmodule

//--- design/ntm_matrix_buffer.sv
// Augmented matrix storage, N_DIM rows by AUG_COLS columns
// One synchronous port, read data one cycle after the read
// Read during write returns the old word
// Contents are undefined until the controller has written them

`timescale 1ns/10ps

module ntm_matrix_buffer (
  input logic         CLK,
  ntm_buf_if.memory   buf_port
);
  import ntm_inverse_pkg::*;

  localparam int DEPTH = N_DIM * AUG_COLS;

  // Row-major, left half A, right half the inverse
  elem_t mem [DEPTH];

  always_ff @(posedge CLK) begin
    if (buf_port.en) begin
      if (buf_port.we)
        mem[buf_port.addr] <= buf_port.wdata;
      // Registered read
      buf_port.rdata <= mem[buf_port.addr];
    end
  end

endmodule

//--- design/ntm_matrix_inverse.sv
// Gauss-Jordan inversion controller for a 4 by 4 Q16.16 matrix
// No pivoting; a zero pivot ends the matrix with the singular flag and zero output
// Products keep bits 47:16 of the full signed product, no saturation
// Input is blocked while a result is computed or streamed

`timescale 1ns/10ps

module ntm_matrix_inverse (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  ntm_inverse_pkg::elem_t in_data,
  output logic                   out_valid,
  input  logic                   out_ready,
  output ntm_inverse_pkg::elem_t out_data,
  output logic                   out_last,
  output logic                   out_singular,
  ntm_recip_if.controller        recip,
  ntm_buf_if.controller          buf_port
);
  import ntm_inverse_pkg::*;

  typedef enum logic [2:0] {
    S_LOAD, S_FETCH, S_RECIP, S_NORM, S_FACTOR, S_ELIM, S_OUT
  } state_t;

  state_t     state;
  // Load count, then identity count, then output read count
  logic [4:0] seq_cnt;
  logic [3:0] out_cnt;
  idx_t       piv;
  idx_t       row;
  idx_t       col;
  logic [1:0] phase;
  logic       singular;

  // Payload registers
  elem_t      pivot_val;
  elem_t      recip_val;
  elem_t      factor;
  elem_t      prow_val;

  // Output pipe, out register plus one skid entry
  logic       rd_inflight;
  logic       skid_valid;
  elem_t      skid_data;
  elem_t      rd_elem;
  logic [1:0] occ;
  logic       pop;
  logic       issue;

  function automatic addr_t addr_of(idx_t r, idx_t c);
    return addr_t'(r) * addr_t'(AUG_COLS) + addr_t'(c);
  endfunction

  // Q16.16 product, full 64 bits then arithmetic shift by 16
  function automatic elem_t q_mul(elem_t a, elem_t b);
    logic signed [2*DATA_W-1:0] prod;
    prod = a * b;
    return prod[FRAC_BITS +: DATA_W];
  endfunction

  // Next row to eliminate, skipping the pivot row
  function automatic idx_t next_row(idx_t r, idx_t p);
    idx_t nr;
    nr = r + idx_t'(1);
    if (nr == p)
      nr = nr + idx_t'(1);
    return nr;
  endfunction

  assign recip.divisor   = pivot_val;
  assign recip.rsp_ready = (state == S_RECIP);

  assign pop          = out_valid && out_ready;
  assign out_last     = out_valid && (out_cnt == 4'(N_DIM * N_DIM - 1));
  assign out_singular = singular;
  assign rd_elem      = singular ? '0 : buf_port.rdata;

  // Items held or on their way; leave room for one more read
  assign occ   = 2'(out_valid) + 2'(skid_valid) + 2'(rd_inflight);
  assign issue = (state == S_OUT) && !seq_cnt[4] && (occ <= 2'(pop) + 2'd1);

  //////////////////////////////
  // Buffer port
  //////////////////////////////

  always_comb begin
    buf_port.en    = 1'b0;
    buf_port.we    = 1'b0;
    buf_port.addr  = '0;
    buf_port.wdata = '0;
    case (state)
      S_LOAD: begin
        // Bit 4 of the count selects the right half
        buf_port.we   = 1'b1;
        buf_port.addr = addr_of(idx_t'(seq_cnt[3:2]), idx_t'({seq_cnt[4], seq_cnt[1:0]}));
        if (!seq_cnt[4]) begin
          buf_port.en    = in_valid && in_ready;
          buf_port.wdata = in_data;
        end else begin
          buf_port.en    = 1'b1;
          buf_port.wdata = (seq_cnt[3:2] == seq_cnt[1:0]) ? Q_ONE : '0;
        end
      end
      S_FETCH: begin
        buf_port.en   = (phase == 2'd0);
        buf_port.addr = addr_of(piv, piv);
      end
      S_NORM: begin
        // Read, then write back scaled by the reciprocal
        buf_port.en    = 1'b1;
        buf_port.we    = (phase == 2'd1);
        buf_port.addr  = addr_of(piv, col);
        buf_port.wdata = q_mul(buf_port.rdata, recip_val);
      end
      S_FACTOR: begin
        buf_port.en   = (phase == 2'd0);
        buf_port.addr = addr_of(row, piv);
      end
      S_ELIM: begin
        // Pivot row element, own element, then write
        buf_port.en    = 1'b1;
        buf_port.we    = (phase == 2'd2);
        buf_port.addr  = (phase == 2'd0) ? addr_of(piv, col) : addr_of(row, col);
        buf_port.wdata = buf_port.rdata - q_mul(factor, prow_val);
      end
      S_OUT: begin
        buf_port.en   = issue;
        buf_port.addr = addr_of(idx_t'(seq_cnt[3:2]), idx_t'({1'b1, seq_cnt[1:0]}));
      end
      default: ;
    endcase
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= S_LOAD;
      seq_cnt         <= '0;
      out_cnt         <= '0;
      piv             <= '0;
      row             <= '0;
      col             <= '0;
      phase           <= '0;
      singular        <= 1'b0;
      in_ready        <= 1'b0;
      recip.req_valid <= 1'b0;
    end else begin
      case (state)
        S_LOAD: begin
          if (!seq_cnt[4]) begin
            if (in_valid && in_ready)
              seq_cnt <= seq_cnt + 5'd1;
            // Close the input after the 16th element
            in_ready <= !(in_valid && in_ready && seq_cnt == 5'(N_DIM * N_DIM - 1));
          end else begin
            seq_cnt <= seq_cnt + 5'd1;
            if (seq_cnt == 5'd31) begin
              piv   <= '0;
              phase <= '0;
              state <= S_FETCH;
            end
          end
        end
        S_FETCH: begin
          phase <= 2'd1;
          if (phase == 2'd1) begin
            phase <= '0;
            if (buf_port.rdata == '0) begin
              singular <= 1'b1;
              seq_cnt  <= '0;
              state    <= S_OUT;
            end else begin
              recip.req_valid <= 1'b1;
              state           <= S_RECIP;
            end
          end
        end
        S_RECIP: begin
          if (recip.req_valid && recip.req_ready)
            recip.req_valid <= 1'b0;
          if (recip.rsp_valid) begin
            col   <= '0;
            state <= S_NORM;
          end
        end
        S_NORM: begin
          phase <= phase ^ 2'd1;
          if (phase == 2'd1) begin
            col <= col + idx_t'(1);
            if (col == idx_t'(AUG_COLS - 1)) begin
              row   <= (piv == '0) ? idx_t'(1) : idx_t'(0);
              state <= S_FACTOR;
            end
          end
        end
        S_FACTOR: begin
          phase <= 2'd1;
          if (phase == 2'd1) begin
            phase <= '0;
            col   <= '0;
            state <= S_ELIM;
          end
        end
        S_ELIM: begin
          phase <= phase + 2'd1;
          if (phase == 2'd2) begin
            phase <= '0;
            col   <= col + idx_t'(1);
            if (col == idx_t'(AUG_COLS - 1)) begin
              if (next_row(row, piv) < idx_t'(N_DIM)) begin
                row   <= next_row(row, piv);
                state <= S_FACTOR;
              end else if (piv == idx_t'(N_DIM - 1)) begin
                seq_cnt <= '0;
                state   <= S_OUT;
              end else begin
                piv   <= piv + idx_t'(1);
                state <= S_FETCH;
              end
            end
          end
        end
        S_OUT: begin
          if (issue)
            seq_cnt <= seq_cnt + 5'd1;
          if (pop) begin
            out_cnt <= out_cnt + 4'd1;
            // Back to load after the last transfer
            if (out_last) begin
              seq_cnt  <= '0;
              singular <= 1'b0;
              state    <= S_LOAD;
            end
          end
        end
        default: state <= S_LOAD;
      endcase
    end
  end

  //////////////////////////////
  // Payload capture
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == S_FETCH && phase == 2'd1)
      pivot_val <= buf_port.rdata;
    if (state == S_RECIP && recip.rsp_valid)
      recip_val <= recip.quotient;
    // Factor is read before the row changes
    if (state == S_FACTOR && phase == 2'd1)
      factor <= buf_port.rdata;
    if (state == S_ELIM && phase == 2'd1)
      prow_val <= buf_port.rdata;
  end

  //////////////////////////////
  // Output skid
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid   <= 1'b0;
      skid_valid  <= 1'b0;
      rd_inflight <= 1'b0;
    end else begin
      rd_inflight <= issue;
      if (!out_valid || out_ready) begin
        // Skid entry drains first
        out_valid  <= skid_valid || rd_inflight;
        skid_valid <= skid_valid && rd_inflight;
      end else if (rd_inflight) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!out_valid || out_ready) begin
      if (skid_valid) begin
        out_data <= skid_data;
        if (rd_inflight)
          skid_data <= rd_elem;
      end else if (rd_inflight) begin
        out_data <= rd_elem;
      end
    end else if (rd_inflight) begin
      skid_data <= rd_elem;
    end
  end

endmodule

//--- design/ntm_recip_if.sv
// Reciprocal request and response channel
// Both halves are valid/ready, with at most one request outstanding

`timescale 1ns/10ps

interface ntm_recip_if;
  import ntm_inverse_pkg::*;

  // Request half
  logic  req_valid;
  logic  req_ready;
  elem_t divisor;

  // Response half, quotient is 2^32 / divisor
  logic  rsp_valid;
  logic  rsp_ready;
  elem_t quotient;

  modport controller (
    output req_valid, divisor, rsp_ready,
    input  req_ready, rsp_valid, quotient
  );

  modport divider (
    input  req_valid, divisor, rsp_ready,
    output req_ready, rsp_valid, quotient
  );

endinterface

//--- design/ntm_scalar_reciprocal.sv
// Iterative restoring divider for the Q16.16 reciprocal 2^32 / divisor
// One item at a time, 34 cycles from accepted request to rsp_valid
// A divisor of zero is not expected; magnitude 1 wraps to zero

`timescale 1ns/10ps

module ntm_scalar_reciprocal (
  input logic           CLK,
  input logic           RST,
  ntm_recip_if.divider  recip
);
  import ntm_inverse_pkg::*;

  typedef enum logic [1:0] {D_IDLE, D_RUN, D_SIGN, D_DONE} div_state_t;

  div_state_t        state;
  logic [5:0]        step;
  logic [DATA_W-1:0] mag;
  logic              neg;
  logic [DATA_W-1:0] rem;
  logic [DATA_W-1:0] quo;
  logic [DATA_W:0]   rem_shift;
  logic              q_bit;

  // Dividend is 2^32, so only the first step shifts in a one
  assign rem_shift = {rem, (step == 6'd0)};
  assign q_bit     = (rem_shift >= {1'b0, mag});

  assign recip.req_ready = (state == D_IDLE);

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= D_IDLE;
      step            <= '0;
      recip.rsp_valid <= 1'b0;
    end else begin
      case (state)
        D_IDLE: begin
          if (recip.req_valid) begin
            step  <= '0;
            state <= D_RUN;
          end
        end
        // 33 quotient bits, bit 32 first
        D_RUN: begin
          step <= step + 6'd1;
          if (step == 6'(DATA_W))
            state <= D_SIGN;
        end
        D_SIGN: begin
          recip.rsp_valid <= 1'b1;
          state           <= D_DONE;
        end
        // Hold result until taken
        D_DONE: begin
          if (recip.rsp_ready) begin
            recip.rsp_valid <= 1'b0;
            state           <= D_IDLE;
          end
        end
        default: state <= D_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == D_IDLE && recip.req_valid) begin
      // Magnitude fits unsigned even for the most negative divisor
      mag <= recip.divisor[DATA_W-1] ? DATA_W'(-recip.divisor) : DATA_W'(recip.divisor);
      neg <= recip.divisor[DATA_W-1];
      rem <= '0;
      quo <= '0;
    end else if (state == D_RUN) begin
      // Restore by keeping the shifted remainder when it is too small
      rem <= q_bit ? DATA_W'(rem_shift - {1'b0, mag}) : rem_shift[DATA_W-1:0];
      // Top quotient bit falls off, which is the intended wrap
      quo <= {quo[DATA_W-2:0], q_bit};
    end
    if (state == D_SIGN)
      recip.quotient <= neg ? -elem_t'(quo) : elem_t'(quo);
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the inversion engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f verilog.f --top-module ntm_inverse_tb \
  -o ntm_inverse_sim > sim.log 2>&1 \
  && ./obj_dir/ntm_inverse_sim >> sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log

cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

//--- verif/ntm_inverse_chk.sv
// Stream protocol checks on the engine top level
// Output must hold under back-pressure, controls stay low in reset

`timescale 1ns/10ps

module ntm_inverse_chk (
  input logic                   CLK,
  input logic                   RST,
  input logic                   in_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input ntm_inverse_pkg::elem_t out_data,
  input logic                   out_last,
  input logic                   out_singular
);
  import ntm_inverse_pkg::*;

  localparam logic [3:0] LAST_IDX = 4'(N_DIM * N_DIM - 1);

  // Result transfers within the current matrix
  logic [3:0] xfer_cnt;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST)
      xfer_cnt <= '0;
    else if (out_valid && out_ready)
      xfer_cnt <= xfer_cnt + 4'd1;
  end

  //////////////////////////////
  // Result stream
  //////////////////////////////

  // Stalled element stays put
  a_out_hold: assert property (@(posedge CLK) disable iff (RST)
    out_valid && !out_ready |=> out_valid && $stable(out_data) &&
      $stable(out_last) && $stable(out_singular))
    else $error("result stream changed while stalled");

  // Last marker on the 16th valid element only
  a_last_pos: assert property (@(posedge CLK) disable iff (RST)
    (out_valid || out_last) |-> out_valid && (out_last == (xfer_cnt == LAST_IDX)))
    else $error("out_last not on the 16th valid result element");

  //////////////////////////////
  // Reset state
  //////////////////////////////

  a_reset_low: assert property (@(posedge CLK)
    RST |-> !in_ready && !out_valid && !out_last)
    else $error("stream controls not low during reset");

endmodule

//--- verif/ntm_inverse_model.svh
// Reference model of the Q16.16 Gauss-Jordan inverse, no pivoting
// Reciprocal truncates toward zero, products keep bits 47:16 with wraparound
// Included inside the testbench module after the package import
// Singular result is all zeros, as the engine streams it

`ifndef NTM_INVERSE_MODEL_SVH
`define NTM_INVERSE_MODEL_SVH

// One matrix in row-major order
typedef elem_t mat_t [N_DIM*N_DIM];

// Full signed product, then arithmetic shift by the fraction width
function automatic elem_t fx_mul(input elem_t a, input elem_t b);
  longint prod;
  prod = longint'(a) * longint'(b);
  return elem_t'(prod >>> FRAC_BITS);
endfunction

// 2^32 over the pivot, low 32 bits kept
function automatic elem_t fx_recip(input elem_t p);
  longint quo;
  quo = (longint'(1) <<< 32) / longint'(p);
  return elem_t'(quo);
endfunction

function automatic void ref_inverse(input mat_t a, output mat_t res, output bit sing);
  elem_t m [N_DIM][AUG_COLS];
  elem_t rcp;
  elem_t f;
  sing = 1'b0;
  // Left half A, right half identity
  for (int r = 0; r < N_DIM; r++) begin
    for (int c = 0; c < AUG_COLS; c++) begin
      if (c < N_DIM)
        m[r][c] = a[r*N_DIM + c];
      else
        m[r][c] = (c - N_DIM == r) ? Q_ONE : '0;
    end
  end
  for (int p = 0; p < N_DIM && !sing; p++) begin
    if (m[p][p] == '0) begin
      sing = 1'b1;
    end else begin
      rcp = fx_recip(m[p][p]);
      for (int c = 0; c < AUG_COLS; c++)
        m[p][c] = fx_mul(m[p][c], rcp);
      for (int r = 0; r < N_DIM; r++) begin
        if (r != p) begin
          // Factor taken before the row changes
          f = m[r][p];
          for (int c = 0; c < AUG_COLS; c++)
            m[r][c] = m[r][c] - fx_mul(f, m[p][c]);
        end
      end
    end
  end
  for (int i = 0; i < N_DIM*N_DIM; i++)
    res[i] = sing ? '0 : m[i / N_DIM][N_DIM + i % N_DIM];
endfunction

`endif

//--- verif/ntm_inverse_tb.sv
// Testbench for the 4 by 4 Q16.16 inversion engine
// Random matrices from a fixed seed, compared with the reference model bit for bit
// Inputs change on the falling edge, outputs are sampled there as well

`timescale 1ns/10ps

module ntm_inverse_tb;
  import ntm_inverse_pkg::*;

  `include "ntm_inverse_model.svh"

  localparam int NUM_ELEM   = N_DIM * N_DIM;
  localparam int WAIT_LIMIT = 4000;
  localparam int Q_SCALE    = 1 << FRAC_BITS;

  logic  CLK;
  logic  RST;
  logic  in_valid;
  logic  in_ready;
  elem_t in_data;
  logic  out_valid;
  logic  out_ready;
  elem_t out_data;
  logic  out_last;
  logic  out_singular;

  int errors;
  int tests_pass;
  int tests_fail;
  int gap_pct;
  int stall_pct;
  bit timeout_hit;
  // Set after the 16th input, cleared by the out_last transfer
  bit result_pending;
  bit last_sing_seen;

  ntm_inverse_top i_dut (
    .CLK          (CLK),
    .RST          (RST),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_data      (in_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_last     (out_last),
    .out_singular (out_singular)
  );

  bind ntm_inverse_top ntm_inverse_chk i_chk (
    .CLK          (CLK),
    .RST          (RST),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_last     (out_last),
    .out_singular (out_singular)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  //////////////////////////////
  // Stimulus builders
  //////////////////////////////

  function automatic mat_t scaled_identity(input elem_t s);
    mat_t m;
    for (int i = 0; i < NUM_ELEM; i++)
      m[i] = (i / N_DIM == i % N_DIM) ? s : '0;
    return m;
  endfunction

  // Diagonal 4.0 to 8.0, off-diagonal within +-1.0
  function automatic mat_t random_dominant();
    mat_t m;
    for (int i = 0; i < NUM_ELEM; i++) begin
      if (i / N_DIM == i % N_DIM)
        m[i] = elem_t'(4 * Q_SCALE + int'($urandom_range(0, 4 * Q_SCALE)));
      else
        m[i] = elem_t'(int'($urandom_range(0, 2 * Q_SCALE)) - Q_SCALE);
    end
    return m;
  endfunction

  //////////////////////////////
  // Stream driver and collector
  //////////////////////////////

  task automatic send_matrix(input mat_t a);
    int idx;
    int waited;
    idx    = 0;
    waited = 0;
    while (idx < NUM_ELEM && !timeout_hit) begin
      @(negedge CLK);
      in_valid = (int'($urandom_range(0, 99)) >= gap_pct);
      in_data  = a[idx];
      assert (!(in_ready && result_pending)) else begin
        $display("in_ready went high before the previous result finished");
        errors++;
      end
      if (in_valid && in_ready) begin
        idx++;
        waited = 0;
        if (idx == NUM_ELEM)
          result_pending = 1'b1;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          $display("Timeout waiting to send input element %0d", idx);
          timeout_hit = 1'b1;
        end
      end
    end
    // Last element goes in on the next rising edge
    @(negedge CLK);
    in_valid = 1'b0;
  endtask

  task automatic collect_result(output mat_t got, output bit sing_at [NUM_ELEM],
                                output bit last_at [NUM_ELEM]);
    int idx;
    int waited;
    idx    = 0;
    waited = 0;
    while (idx < NUM_ELEM && !timeout_hit) begin
      @(negedge CLK);
      out_ready = (int'($urandom_range(0, 99)) >= stall_pct);
      if (out_valid && out_ready) begin
        got[idx]     = out_data;
        sing_at[idx] = out_singular;
        last_at[idx] = out_last;
        if (out_last)
          result_pending = 1'b0;
        idx++;
        waited = 0;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          $display("Timeout waiting for result element %0d", idx);
          timeout_hit = 1'b1;
        end
      end
    end
  endtask

  //////////////////////////////
  // Comparison
  //////////////////////////////

  task automatic check_result(input string tag, input mat_t a, input mat_t got,
                              input bit sing_at [NUM_ELEM], input bit last_at [NUM_ELEM]);
    mat_t exp;
    bit   exp_sing;
    ref_inverse(a, exp, exp_sing);
    if (!timeout_hit) begin
      for (int i = 0; i < NUM_ELEM; i++) begin
        assert (got[i] == exp[i]) else begin
          $display("MISMATCH %s out_data[%0d]: expected %h, got %h", tag, i, exp[i], got[i]);
          errors++;
        end
        assert (sing_at[i] == exp_sing) else begin
          $display("MISMATCH %s out_singular[%0d]: expected %h, got %h",
                   tag, i, exp_sing, sing_at[i]);
          errors++;
        end
        assert (last_at[i] == (i == NUM_ELEM - 1)) else begin
          $display("MISMATCH %s out_last[%0d]: expected %h, got %h",
                   tag, i, (i == NUM_ELEM - 1), last_at[i]);
          errors++;
        end
      end
      last_sing_seen = sing_at[NUM_ELEM-1];
    end
  endtask

  task automatic run_matrix(input string tag, input mat_t a);
    mat_t got;
    bit   sing_at [NUM_ELEM];
    bit   last_at [NUM_ELEM];
    send_matrix(a);
    collect_result(got, sing_at, last_at);
    check_result(tag, a, got, sing_at, last_at);
  endtask

  // Second matrix offered while the first is still in flight
  task automatic run_pair(input string tag, input mat_t a, input mat_t b);
    mat_t got_a;
    mat_t got_b;
    bit   sing_a [NUM_ELEM];
    bit   last_a [NUM_ELEM];
    bit   sing_b [NUM_ELEM];
    bit   last_b [NUM_ELEM];
    fork
      begin
        send_matrix(a);
        send_matrix(b);
      end
      begin
        collect_result(got_a, sing_a, last_a);
        collect_result(got_b, sing_b, last_b);
      end
    join
    check_result({tag, "_a"}, a, got_a, sing_a, last_a);
    check_result({tag, "_b"}, b, got_b, sing_b, last_b);
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before && !timeout_hit) begin
      tests_pass++;
      $display("PASS %s", name);
    end else begin
      tests_fail++;
      $display("FAIL %s", name);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int   err_before;
    int   seed_ret;
    mat_t a;
    seed_ret       = $urandom(32'h0bf73f0f);
    CLK            = 1'b0;
    RST            = 1'b1;
    in_valid       = 1'b0;
    in_data        = '0;
    out_ready      = 1'b0;
    errors         = 0;
    tests_pass     = 0;
    tests_fail     = 0;
    gap_pct        = 0;
    stall_pct      = 0;
    timeout_hit    = 1'b0;
    result_pending = 1'b0;
    last_sing_seen = 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Identity and scaled identity
    err_before = errors;
    run_matrix("identity", scaled_identity(Q_ONE));
    run_matrix("scaled_2", scaled_identity(elem_t'(2 * Q_SCALE)));
    run_matrix("scaled_neg_quarter", scaled_identity(-elem_t'(Q_SCALE / 4)));
    finish_test("identity_and_scaled", err_before);

    // Well conditioned random set
    err_before = errors;
    for (int n = 0; n < 20; n++)
      run_matrix($sformatf("dominant_%0d", n), random_dominant());
    finish_test("random_dominant", err_before);

    // First pivot zero, then second pivot cancelled by elimination
    err_before = errors;
    a    = random_dominant();
    a[0] = '0;
    run_matrix("first_pivot_zero", a);
    assert (last_sing_seen || timeout_hit) else begin
      $display("Singular flag not raised for a zero first pivot");
      errors++;
    end
    a    = scaled_identity(Q_ONE);
    a[1] = elem_t'(2 * Q_SCALE);
    a[4] = elem_t'(2 * Q_SCALE);
    a[5] = elem_t'(4 * Q_SCALE);
    a[6] = Q_ONE;
    run_matrix("second_pivot_zero", a);
    assert (last_sing_seen || timeout_hit) else begin
      $display("Singular flag not raised for a cancelled second pivot");
      errors++;
    end
    finish_test("zero_pivot", err_before);

    // Output stalls about 40% of cycles
    err_before = errors;
    stall_pct  = 40;
    for (int n = 0; n < 10; n++)
      run_matrix($sformatf("stall_%0d", n), random_dominant());
    finish_test("random_backpressure", err_before);

    // Input gaps with overlapping matrices
    err_before = errors;
    gap_pct    = 30;
    stall_pct  = 20;
    for (int n = 0; n < 3; n++)
      run_pair($sformatf("pair_%0d", n), random_dominant(), random_dominant());
    finish_test("gaps_back_to_back", err_before);

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_pass, tests_fail, errors);
    if (tests_fail == 0 && errors == 0 && !timeout_hit)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verif
design/ntm_inverse_pkg.sv
design/ntm_recip_if.sv
design/ntm_buf_if.sv
design/ntm_scalar_reciprocal.sv
design/ntm_matrix_buffer.sv
design/ntm_matrix_inverse.sv
design/ntm_inverse_top.sv
verif/ntm_inverse_chk.sv
verif/ntm_inverse_tb.sv
